// ==== aesCore.f ====
logic/aesPkg.sv
logic/sboxLut.sv
logic/subBytesStage.sv
logic/keySchedule.sv
logic/roundDatapath.sv
logic/aesControl.sv
logic/aesCore.sv
testbench/aesCoreTb.sv

// ==== testbench/aesTests.mem ====
// one vector per line, 384 bits written as 96 hex digits
// columns: key (383:256), plaintext (255:128), expected ciphertext (127:0)
// fips-197 appendix c.1
000102030405060708090a0b0c0d0e0f00112233445566778899aabbccddeeff69c4e0d86a7b0430d8cdb78070b4c55a
// fips-197 appendix b
2b7e151628aed2a6abf7158809cf4f3c3243f6a8885a308d313198a2e03707343925841d02dc09fbdc118597196a0b32
// all-zero key and plaintext
000000000000000000000000000000000000000000000000000000000000000066e94bd4ef8a2c3b884cfa59ca342b2e
// all-ones key, zero plaintext
ffffffffffffffffffffffffffffffff00000000000000000000000000000000a1f6258c877d5fcd8964484538bfc92c
// zero key, all-ones plaintext
00000000000000000000000000000000ffffffffffffffffffffffffffffffff3f5b8cc9ea855a0afa7347d23e8d664e
// ecb blocks from sp 800-38a
2b7e151628aed2a6abf7158809cf4f3c6bc1bee22e409f96e93d7e117393172a3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3cae2d8a571e03ac9c9eb76fac45af8e51f5d3d58503b9699de785895a96fdbaaf
00000000000000000000000000000000f34481ec3cc627bacd5dc3fb08f273e60336763e966d92595a567cc9ce537f5e

// ==== testbench/aesCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aesCoreTb;

    localparam int numVectors  = 8;
    localparam int latency     = 2 * aesPkg::numRounds;  // start edge to done
    localparam int doneTimeout = 40;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic [127:0] key;
    logic [127:0] plaintext;
    logic         busy;
    logic         done;
    logic [127:0] ciphertext;

    logic [383:0] tests [0:numVectors-1];  // key, plaintext, expected ciphertext

    int valueErrors;
    int otherErrors;
    int seed;

    aesCore dut0
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .key        (key),
        .plaintext  (plaintext),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    task automatic reportMismatch(input string name, input logic [127:0] expVal,
                                  input logic [127:0] actVal);
        $display("ERR t=%0t %s expected %0h got %0h", $time, name, expVal, actVal);
        valueErrors++;
    endtask

    // call right after a rising edge
    task automatic launch(input logic [127:0] newKey, input logic [127:0] newPt);
        start     <= 1'b1;
        key       <= newKey;
        plaintext <= newPt;
    endtask

    // idle cycles, result must stay put
    task automatic idleGap(input int cycles, input logic [127:0] heldCt);
        int n;
        for (n = 0; n < cycles; n++)
        begin
            @(posedge clk);
            @(negedge clk);
            if (ciphertext !== heldCt)
            begin
                reportMismatch("ciphertext", heldCt, ciphertext);
            end
            if (busy !== 1'b0)
            begin
                reportMismatch("busy", 1'b0, busy);
            end
            if (done !== 1'b0)
            begin
                reportMismatch("done", 1'b0, done);
            end
        end
    endtask

    // entered after the edge that drove start, first edge here is edge 0
    task automatic runVector(input int idx, input logic [127:0] heldCt,
                             input bit busyStart, input bit chainNext);
        logic [127:0] vecKey;
        logic [127:0] vecPt;
        logic [127:0] expCt;
        int           k;
        bit           seenDone;
        vecKey   = tests[idx][383:256];
        vecPt    = tests[idx][255:128];
        expCt    = tests[idx][127:0];
        k        = 0;
        seenDone = 1'b0;
        while (!seenDone && k < doneTimeout)
        begin
            @(posedge clk);
            if (k == 0)
            begin
                start <= 1'b0;
            end
            if (busyStart && k == 6)
            begin
                launch(~vecKey, ~vecPt);  // must be ignored
            end
            if (busyStart && k == 7)
            begin
                start <= 1'b0;
            end
            if (chainNext && k == latency)
            begin
                launch(tests[idx + 1][383:256], tests[idx + 1][255:128]);  // lands in done cycle
            end
            @(negedge clk);
            if (done === 1'b1)
            begin
                seenDone = 1'b1;
                if (k != latency)
                begin
                    reportMismatch("done latency", latency, k);
                end
                if (busy !== 1'b0)
                begin
                    reportMismatch("busy", 1'b0, busy);
                end
                if (ciphertext !== expCt)
                begin
                    reportMismatch("ciphertext", expCt, ciphertext);
                end
            end
            else
            begin
                if (busy !== 1'b1)
                begin
                    reportMismatch("busy", 1'b1, busy);
                end
                if (ciphertext !== heldCt)
                begin
                    reportMismatch("ciphertext", heldCt, ciphertext);
                end
                k++;
            end
        end
        if (!seenDone)
        begin
            $display("timeout: vector %0d gave no done within %0d cycles", idx, doneTimeout);
            otherErrors++;
        end
    endtask

    initial
    begin
        int           i;
        int           gap;
        bit           launched;
        bit           chainNext;
        logic [127:0] lastCt;
        valueErrors = 0;
        otherErrors = 0;
        seed        = 32'h22cc;
        gap         = $urandom(seed);
        rst_n       = 1'b0;
        start       = 1'b0;
        key         = '0;
        plaintext   = '0;
        $readmemh("testbench/aesTests.mem", tests);
        if ($isunknown(tests[numVectors - 1]))
        begin
            $display("test vectors could not be read from testbench/aesTests.mem");
            otherErrors++;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0)
        begin
            reportMismatch("busy", 1'b0, busy);
        end
        if (done !== 1'b0)
        begin
            reportMismatch("done", 1'b0, done);
        end
        if (ciphertext !== 128'h0)
        begin
            reportMismatch("ciphertext", 128'h0, ciphertext);
        end

        lastCt   = '0;
        launched = 1'b0;
        for (i = 0; i < numVectors; i++)
        begin
            if (!launched)
            begin
                gap = $urandom % 6;
                idleGap(gap, lastCt);
                @(posedge clk);
                launch(tests[i][383:256], tests[i][255:128]);
            end
            chainNext = (i % 3 == 2) && (i + 1 < numVectors);
            runVector(i, lastCt, (i % 3 == 1), chainNext);
            lastCt   = tests[i][127:0];
            launched = chainNext;
        end
        idleGap(4, lastCt);

        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/aesCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aesCore
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         start,
    input  wire logic [aesPkg::blockBits-1:0] key,
    input  wire logic [aesPkg::blockBits-1:0] plaintext,
    output logic                              busy,
    output logic                              done,
    output logic      [aesPkg::blockBits-1:0] ciphertext
);

    aesPkg::roundStepT            roundStep;
    logic [3:0]                   roundIndex;
    logic [aesPkg::blockBits-1:0] stateWord;
    logic [aesPkg::blockBits-1:0] subWord;
    logic [aesPkg::blockBits-1:0] nextRoundKey;

    aesControl uControl
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .roundStep  (roundStep),
        .roundIndex (roundIndex)
    );

    // shared substitution for the state, one cycle ahead of each round write
    subBytesStage uSubBytes
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .stateWord (stateWord),
        .subWord   (subWord)
    );

    keySchedule uKeySchedule
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .roundStep    (roundStep),
        .roundIndex   (roundIndex),
        .nextRoundKey (nextRoundKey)
    );

    roundDatapath uDatapath
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .plaintext    (plaintext),
        .key          (key),
        .roundStep    (roundStep),
        .subWord      (subWord),
        .nextRoundKey (nextRoundKey),
        .stateWord    (stateWord),
        .ciphertext   (ciphertext)
    );

endmodule

`default_nettype wire

// ==== logic/aesControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module aesControl
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         start,
    output logic              busy,
    output logic              done,
    output aesPkg::roundStepT roundStep,
    output logic [3:0]        roundIndex
);

    aesPkg::ctrlStateT ctrlState;
    logic [3:0]        roundCount;
    logic              doneReg;
    logic              lastRound;

    assign lastRound  = (roundCount == 4'(aesPkg::numRounds));
    assign roundIndex = roundCount;
    assign busy       = (ctrlState != aesPkg::IDLE);
    assign done       = doneReg;

    // load must act on the edge that samples start
    always_comb
    begin
        case (ctrlState)
            aesPkg::IDLE: roundStep = start ? aesPkg::ROUND_LOAD : aesPkg::ROUND_IDLE;
            aesPkg::SUB:  roundStep = aesPkg::ROUND_SUB;
            aesPkg::MIX:  roundStep = lastRound ? aesPkg::ROUND_FINAL : aesPkg::ROUND_MIX;
            default:      roundStep = aesPkg::ROUND_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrlState  <= aesPkg::IDLE;
            roundCount <= 4'd0;
            doneReg    <= 1'b0;
        end
        else
        begin
            doneReg <= 1'b0;
            case (ctrlState)
                aesPkg::IDLE:
                begin
                    if (start)
                    begin
                        ctrlState  <= aesPkg::SUB;
                        roundCount <= 4'd1;
                    end
                end
                aesPkg::SUB:
                begin
                    ctrlState <= aesPkg::MIX;
                end
                aesPkg::MIX:
                begin
                    if (lastRound)
                    begin
                        ctrlState <= aesPkg::IDLE;
                        doneReg   <= 1'b1;  // ciphertext written on this edge
                    end
                    else
                    begin
                        ctrlState  <= aesPkg::SUB;
                        roundCount <= roundCount + 4'd1;
                    end
                end
                default:
                begin
                    ctrlState <= aesPkg::IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

    assert property (@(posedge clk) disable iff (!rst_n)
        !(done && roundStep == aesPkg::ROUND_SUB));

    assert property (@(posedge clk) disable iff (!rst_n)
        roundIndex <= 4'(aesPkg::numRounds));

endmodule

`default_nettype wire

// ==== logic/roundDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module roundDatapath
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [aesPkg::blockBits-1:0] plaintext,
    input  wire logic [aesPkg::blockBits-1:0] key,
    input  wire aesPkg::roundStepT            roundStep,
    input  wire logic [aesPkg::blockBits-1:0] subWord,
    input  wire logic [aesPkg::blockBits-1:0] nextRoundKey,
    output logic      [aesPkg::blockBits-1:0] stateWord,
    output logic      [aesPkg::blockBits-1:0] ciphertext
);

    logic [aesPkg::blockBits-1:0] shifted;
    logic [aesPkg::blockBits-1:0] mixed;

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});  // gf(2^8) doubling
    endfunction

    // byte index is row + 4 * column, row r rotates left by r
    function automatic logic [127:0] shiftRows(input logic [127:0] s);
        logic [127:0] r;
        int c;
        int rw;
        for (c = 0; c < 4; c++)
        begin
            for (rw = 0; rw < 4; rw++)
            begin
                r[127 - 8 * (rw + 4 * c) -: 8] = s[127 - 8 * (rw + 4 * ((c + rw) % 4)) -: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [127:0] mixColumns(input logic [127:0] s);
        logic [127:0] r;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        int c;
        for (c = 0; c < 4; c++)
        begin
            a0 = s[127 - 32 * c -: 8];
            a1 = s[119 - 32 * c -: 8];
            a2 = s[111 - 32 * c -: 8];
            a3 = s[103 - 32 * c -: 8];
            r[127 - 32 * c -: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            r[119 - 32 * c -: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            r[111 - 32 * c -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            r[103 - 32 * c -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return r;
    endfunction

    assign shifted = shiftRows(subWord);
    assign mixed   = mixColumns(shifted);

    always_ff @(posedge clk)
    begin
        case (roundStep)
            aesPkg::ROUND_LOAD:  stateWord <= plaintext ^ key;  // round 0 key add
            aesPkg::ROUND_MIX:   stateWord <= mixed ^ nextRoundKey;
            aesPkg::ROUND_FINAL: stateWord <= shifted ^ nextRoundKey;
            default:             stateWord <= stateWord;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ciphertext <= '0;
        end
        else if (roundStep == aesPkg::ROUND_FINAL)
        begin
            ciphertext <= shifted ^ nextRoundKey;  // held until the next final round
        end
    end

endmodule

`default_nettype wire

// ==== logic/keySchedule.sv ====
`timescale 1ns/1ps
`default_nettype none

module keySchedule
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [aesPkg::blockBits-1:0] key,
    input  wire aesPkg::roundStepT            roundStep,
    input  wire logic [3:0]                   roundIndex,
    output logic      [aesPkg::blockBits-1:0] nextRoundKey
);

    logic [aesPkg::blockBits-1:0] roundKey;
    logic [31:0] subLast;  // s-box of the last key word, one cycle late
    logic [31:0] temp;
    logic [7:0]  rcon;
    logic        writeStep;

    // the lookups sample every edge, the SUB step keeps roundKey steady for them
    genvar i;
    generate
        for (i = 0; i < 4; i++)
        begin : gKeySbox
            sboxLut uSbox
            (
                .clk     (clk),
                .rst_n   (rst_n),
                .sboxIn  (roundKey[31 - 8 * i -: 8]),
                .sboxOut (subLast[31 - 8 * i -: 8])
            );
        end
    endgenerate

    always_comb
    begin
        case (roundIndex)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;
        endcase
    end

    assign temp = {subLast[23:0], subLast[31:24]} ^ {rcon, 24'h000000};  // rotword after subword

    assign nextRoundKey[127:96] = roundKey[127:96] ^ temp;
    assign nextRoundKey[95:64]  = roundKey[95:64] ^ nextRoundKey[127:96];
    assign nextRoundKey[63:32]  = roundKey[63:32] ^ nextRoundKey[95:64];
    assign nextRoundKey[31:0]   = roundKey[31:0] ^ nextRoundKey[63:32];

    assign writeStep = (roundStep == aesPkg::ROUND_MIX) || (roundStep == aesPkg::ROUND_FINAL);

    always_ff @(posedge clk)
    begin
        if (roundStep == aesPkg::ROUND_LOAD)
        begin
            roundKey <= key;
        end
        else if (writeStep)
        begin
            roundKey <= nextRoundKey;  // same edge as the state write
        end
    end

    // rcon lookup only defined for rounds 1 to 10
    assert property (@(posedge clk) disable iff (!rst_n)
        writeStep |-> (roundIndex >= 4'd1 && roundIndex <= 4'(aesPkg::numRounds)));

endmodule

`default_nettype wire

// ==== logic/subBytesStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module subBytesStage
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [aesPkg::blockBits-1:0] stateWord,
    output logic      [aesPkg::blockBits-1:0] subWord
);

    localparam int numBytes = aesPkg::blockBits / 8;

    // byte 0 sits in the top bits, as in the FIPS-197 byte order
    genvar i;
    generate
        for (i = 0; i < numBytes; i++)
        begin : gSbox
            sboxLut uSbox
            (
                .clk     (clk),
                .rst_n   (rst_n),
                .sboxIn  (stateWord[aesPkg::blockBits - 1 - 8 * i -: 8]),
                .sboxOut (subWord[aesPkg::blockBits - 1 - 8 * i -: 8])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// ==== logic/sboxLut.sv ====
`timescale 1ns/1ps
`default_nettype none

module sboxLut
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [7:0] sboxIn,
    output logic      [7:0] sboxOut
);

    logic [127:0] row;  // one table row per upper nibble

    always_comb
    begin
        case (sboxIn[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
            default: row = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sboxOut <= 8'h00;
        end
        else
        begin
            sboxOut <= row[127 - 8 * sboxIn[3:0] -: 8];  // lower nibble picks the byte
        end
    end

endmodule

`default_nettype wire

// ==== logic/aesPkg.sv ====
`default_nettype none

package aesPkg;

    localparam int blockBits = 128;
    localparam int numRounds = 10;

    // what the datapath does on the coming edge
    typedef enum logic [2:0]
    {
        ROUND_IDLE,
        ROUND_LOAD,  // key whitening, key register load
        ROUND_SUB,   // s-boxes sample state and key word
        ROUND_MIX,
        ROUND_FINAL  // no mixcolumns
    } roundStepT;

    typedef enum logic [1:0]
    {
        IDLE,
        SUB,
        MIX
    } ctrlStateT;

endpackage

`default_nettype wire
